/* bench/fsab_fabric_properties.sv */
`timescale 1ns/1ps
`include "fsab_cfg.svh"

module fsab_fabric_properties (
	input  logic                      cclk,
	input  logic                      core_rst_b,
	input  logic                      rst_done,
	input  logic [`FSAB_CLIENTS-1:0]  client_valid,
	input  logic [`FSAB_CLIENTS-1:0]  client_credit,
	input  logic [`FSAB_CLIENTS-1:0]  q_pop,
	input  logic                      grant_valid,
	input  logic                      fsabo_valid,
	input  logic                      fsabo_credit
);

	localparam int CLIENTS = `FSAB_CLIENTS;
	localparam int CREDITS = `FSAB_MEM_CREDITS;
	localparam int DEPTH   = `FSAB_QUEUE_DEPTH;

	int outstanding;          // Grants not yet paid back by memory
	int occ [CLIENTS];        // Entries held per queue
	int fail_cnt = 0;         // Assertion failures so far

	always_ff @(posedge cclk or negedge core_rst_b) begin
		if (!core_rst_b) begin
			outstanding <= 0;
			for (int i = 0; i < CLIENTS; i++) begin
				occ[i] <= 0;
			end
		end else begin
			outstanding <= outstanding + int'(grant_valid) - int'(fsabo_credit);
			for (int i = 0; i < CLIENTS; i++) begin
				occ[i] <= occ[i] + int'(client_valid[i]) - int'(q_pop[i]);
			end
		end
	end

	// Bus and credits quiet while held in reset
	a_quiet_in_reset: assert property (@(posedge cclk)
		!rst_done |-> (!fsabo_valid && client_credit == '0))
		else begin
			fail_cnt++;
			$error("bus strobe or client credit active before reset release");
		end

	a_credit_range: assert property (@(posedge cclk) disable iff (!core_rst_b)
		(outstanding >= 0 && outstanding <= CREDITS))
		else begin
			fail_cnt++;
			$error("memory credits outstanding out of range: %0d", outstanding);
		end

	a_single_pop: assert property (@(posedge cclk) disable iff (!core_rst_b)
		$onehot0(q_pop))
		else begin
			fail_cnt++;
			$error("more than one queue popped in one cycle");
		end

	// Write into a full queue breaks the client credit rule
	for (genvar i = 0; i < CLIENTS; i++) begin : g_occ
		a_no_overflow: assert property (@(posedge cclk) disable iff (!core_rst_b)
			client_valid[i] |-> occ[i] < DEPTH)
			else begin
				fail_cnt++;
				$error("client %0d wrote into a full queue", i);
			end
	end

endmodule

bind fsab_fabric fsab_fabric_properties u_properties (
	.cclk          (cclk),
	.core_rst_b    (core_rst_b),
	.rst_done      (rst_done),
	.client_valid  (client_valid),
	.client_credit (client_credit),
	.q_pop         (q_pop),
	.grant_valid   (grant_valid),
	.fsabo_valid   (fsabo_valid),
	.fsabo_credit  (fsabo_credit)
);

/* bench/fsab_fabric_tb.sv */
`timescale 1ns/1ps
`include "fsab_cfg.svh"

module fsab_fabric_tb import fsab_pkg::*; ();

	localparam int CLIENTS   = `FSAB_CLIENTS;
	localparam int DID_W     = `FSAB_DID_W;
	localparam int ADDR_W    = `FSAB_ADDR_W;
	localparam int DATA_W    = `FSAB_DATA_W;
	localparam int MASK_W    = `FSAB_MASK_W;
	localparam int LEN_W     = `FSAB_LEN_W;
	localparam int DEPTH     = `FSAB_QUEUE_DEPTH;
	localparam int STAGES    = `FSAB_RST_STAGES;
	localparam int FLASH     = `FSAB_FLASH_CYCLES;
	localparam int BUS_W     = 2 * DID_W + 1 + ADDR_W + LEN_W + DATA_W + MASK_W;
	localparam int PERIOD_NS = 4;
	localparam int N_REQ     = 150;       // Sum over all phases
	localparam int WORST_LAT = 48;        // Cycles, covers full queues and withheld credits

	logic                                cclk;
	logic                                cclk_rst_cause_b;
	logic [CLIENTS-1:0]                  client_valid;
	logic [CLIENTS-1:0]                  client_mode;
	logic [CLIENTS-1:0][DID_W-1:0]       client_subdid;
	logic [CLIENTS-1:0][ADDR_W-1:0]      client_addr;
	logic [CLIENTS-1:0][LEN_W-1:0]       client_len;
	logic [CLIENTS-1:0][DATA_W-1:0]      client_data;
	logic [CLIENTS-1:0][MASK_W-1:0]      client_mask;
	logic [CLIENTS-1:0]                  client_credit;
	logic                                fsabo_valid;
	fsab_mode_e                          fsabo_mode;
	logic [DID_W-1:0]                    fsabo_did;
	logic [DID_W-1:0]                    fsabo_subdid;
	logic [ADDR_W-1:0]                   fsabo_addr;
	logic [LEN_W-1:0]                    fsabo_len;
	logic [DATA_W-1:0]                   fsabo_data;
	logic [MASK_W-1:0]                   fsabo_mask;
	logic                                fsabo_credit;
	logic                                rst_done;
	logic                                read_seen;
	logic                                read_recent;

	logic [15:0]         lfsr_state;                 // Fibonacci LFSR, x^16+x^14+x^13+x^11+1
	logic [BUS_W-1:0]    exp_q [CLIENTS][$];          // Expected bus words per client
	int                  cred [CLIENTS];              // Client side credit models
	int                  sent_cnt [CLIENTS];          // Updated nonblocking, read by compare
	int                  sent_old [CLIENTS];          // Sent two edges back
	int                  issued_cnt [CLIENTS];
	logic [CLIENTS-1:0]  served_while [CLIENTS];      // Who got issued while client waited
	int                  sent_total;
	int                  issued_tb;
	int                  mem_out;                     // Issued minus returned memory credits
	int                  to_send;
	int                  cyc;
	int                  last_read;
	int                  did;
	logic [BUS_W-1:0]    act;

	fsab_fabric UUT (.*);

	initial begin : clock_gen
		cclk = 1'b0;
		forever #(PERIOD_NS / 2) cclk = ~cclk;
	end

	initial begin : watchdog
		#((N_REQ * WORST_LAT + STAGES + FLASH) * PERIOD_NS);
		abort_run("watchdog expired, traffic did not drain in time");
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		if (expected !== actual) begin
			abort_run($sformatf("CHECK FAILED %s: expected %0h, actual %0h",
				name, expected, actual));
		end
	endtask

	// One LFSR step per bit taken
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			r          = {r[62:0], fb};
		end
		return r;
	endfunction

	// Bus word a sent request must show, device id is the client number
	function automatic logic [BUS_W-1:0] expect_word(input int client, input logic mode,
		input logic [DID_W-1:0] subdid, input logic [ADDR_W-1:0] addr,
		input logic [LEN_W-1:0] len, input logic [DATA_W-1:0] data,
		input logic [MASK_W-1:0] mask);
		return {DID_W'(client), mode, subdid, addr, len, data, mask};
	endfunction

	task automatic send_request(input int c, input bit writes_only);
		client_mode[c]   = writes_only ? 1'b1 : 1'(rand_bits(1));
		client_subdid[c] = DID_W'(rand_bits(DID_W));
		client_addr[c]   = ADDR_W'(rand_bits(ADDR_W));
		client_len[c]    = LEN_W'(rand_bits(LEN_W));
		client_data[c]   = DATA_W'(rand_bits(DATA_W));
		client_mask[c]   = MASK_W'(rand_bits(MASK_W));
		client_valid[c]  = 1'b1;
		exp_q[c].push_back(expect_word(c, client_mode[c], client_subdid[c], client_addr[c],
			client_len[c], client_data[c], client_mask[c]));
		cred[c]     = cred[c] - 1;                        // Spent on this strobe
		sent_cnt[c] <= sent_cnt[c] + 1;
		sent_total  = sent_total + 1;
		to_send     = to_send - 1;
	endtask

	// Client and memory models for one clock
	task automatic step_cycle(input bit writes_only, input bit saturate, input bit withhold);
		@(negedge cclk);
		client_valid = '0;
		fsabo_credit = 1'b0;
		for (int c = 0; c < CLIENTS; c++) begin
			if (client_credit[c]) begin
				cred[c] = cred[c] + 1;
			end
			if (cred[c] > DEPTH) begin
				abort_run($sformatf("client %0d got back more credits than it spent", c));
			end
		end
		if (fsabo_valid) begin
			mem_out   = mem_out + 1;
			issued_tb = issued_tb + 1;
		end
		if (mem_out > `FSAB_MEM_CREDITS) begin
			abort_run("fabric issued more requests than memory credits allow");
		end
		if (!withhold && mem_out > 0 && rand_bits(1) != 0) begin
			fsabo_credit = 1'b1;                          // Only for issued requests
			mem_out      = mem_out - 1;
		end
		for (int c = 0; c < CLIENTS; c++) begin
			if (to_send > 0 && cred[c] > 0 && (saturate || rand_bits(1) != 0)) begin
				send_request(c, writes_only);
			end
		end
	endtask

	function automatic bit idle();
		bit quiet;
		quiet = (issued_tb == sent_total) && (mem_out == 0);
		for (int c = 0; c < CLIENTS; c++) begin
			quiet = quiet && (cred[c] == DEPTH);          // All credits back home
		end
		return quiet;
	endfunction

	task automatic run_phase(input int n, input bit writes_only, input bit saturate,
		input int withhold_cycles);
		int k;
		k       = 0;
		to_send = n;
		while (to_send > 0 || !idle()) begin
			step_cycle(writes_only, saturate, k < withhold_cycles);
			k = k + 1;
		end
	endtask

	initial begin : stimulus
		int cycles;
		lfsr_state       = 16'd22437;
		cclk_rst_cause_b = 1'b0;
		client_valid     = '0;
		client_mode      = '0;
		client_subdid    = '0;
		client_addr      = '0;
		client_len       = '0;
		client_data      = '0;
		client_mask      = '0;
		fsabo_credit     = 1'b0;
		sent_total       = 0;
		issued_tb        = 0;
		mem_out          = 0;
		for (int c = 0; c < CLIENTS; c++) begin
			sent_cnt[c] = 0;
			cred[c]     = 0;
		end
		repeat (2) @(negedge cclk);
		cclk_rst_cause_b = 1'b1;
		cycles = 0;
		while (!rst_done) begin                           // Count release sequence
			check_value("controls low in reset", '0,
				{client_credit, fsabo_valid, read_seen, read_recent});
			@(negedge cclk);
			cycles = cycles + 1;
			if (cycles > 4 * STAGES) begin
				abort_run("rst_done never rose after reset cause release");
			end
		end
		check_value("reset release cycles", STAGES, cycles);
		for (int c = 0; c < CLIENTS; c++) begin
			cred[c] = DEPTH;
		end
		run_phase(30, 1'b1, 1'b0, 0);                    // Writes only
		run_phase(60, 1'b0, 1'b0, 40);                   // Mixed, memory credits held back
		run_phase(60, 1'b0, 1'b1, 0);                    // All queues kept busy
		@(negedge cclk);
		fsabo_credit = 1'b0;                             // Last credit pulse ends here
		repeat (FLASH + 3) @(negedge cclk);              // Let the flash run out
		$display("TEST PASSED");
		$finish;
	end

	initial begin
		cyc       = 0;
		last_read = 0;
		for (int c = 0; c < CLIENTS; c++) begin
			sent_old[c]     = 0;
			issued_cnt[c]   = 0;
			served_while[c] = '0;
		end
	end

	// Bound assertions count their failures
	always @(negedge cclk) begin : assert_watch
		if (UUT.u_properties.fail_cnt != 0) begin
			abort_run("a bound assertion on the fabric failed");
		end
	end

	// Bus and status compare, outputs sampled mid-cycle
	always @(negedge cclk) begin : compare_bus
		if (rst_done) begin
			cyc = cyc + 1;
			check_value("read_seen", last_read > 0, read_seen);
			check_value("read_recent", last_read > 0 && cyc - last_read <= FLASH, read_recent);
			if (fsabo_valid) begin
				did = int'(fsabo_did);
				if (did >= CLIENTS) begin
					abort_run($sformatf("device id %0d names no client", did));
				end
				if (exp_q[did].size() == 0) begin
					abort_run($sformatf("client %0d issued a request it never sent", did));
				end
				act = {fsabo_did, fsabo_mode, fsabo_subdid, fsabo_addr, fsabo_len,
					fsabo_data, fsabo_mask};
				check_value($sformatf("bus word client %0d", did), exp_q[did].pop_front(), act);
				for (int j = 0; j < CLIENTS; j++) begin
					if (j == did || sent_old[j] == issued_cnt[j]) begin
						served_while[j] = '0;             // Not waiting at this grant
					end else if (served_while[j][did]) begin
						abort_run($sformatf("client %0d issued twice while client %0d waited",
							did, j));
					end else begin
						served_while[j][did] = 1'b1;
					end
				end
				issued_cnt[did] = issued_cnt[did] + 1;
				if (fsabo_mode == FSAB_READ) begin
					last_read = cyc;                      // Flash runs from here
				end
			end
			for (int c = 0; c < CLIENTS; c++) begin
				sent_old[c] = sent_cnt[c];                // Nonblocking count, one edge old
			end
		end
	end

endmodule

/* fsab_fabric.f */
+incdir+src
src/fsab_pkg.sv
src/fsab_client_queue.sv
src/fsab_arbiter.sv
src/fsab_issue.sv
src/fsab_fabric.sv
bench/fsab_fabric_properties.sv
bench/fsab_fabric_tb.sv

/* src/fsab_arbiter.sv */
`timescale 1ns/1ps
`include "fsab_cfg.svh"

module fsab_arbiter import fsab_pkg::*; (
	input  logic                         cclk,
	input  logic                         core_rst_b,
	input  logic [`FSAB_CLIENTS-1:0]     q_nonempty,   // One bit per queue
	input  fsab_req_t                    q_head [`FSAB_CLIENTS],
	input  logic                         fsabo_credit, // Memory returns one credit
	output logic [`FSAB_CLIENTS-1:0]     q_pop,        // One-hot when granting
	output logic                         grant_valid,
	output fsab_req_t                    grant_req,
	output logic [`FSAB_DID_W-1:0]       grant_did     // Winning client number
);

	localparam int CLIENTS = `FSAB_CLIENTS;
	localparam int CW      = (CLIENTS > 1) ? $clog2(CLIENTS) : 1;
	localparam int CREDITS = `FSAB_MEM_CREDITS;
	localparam int CRD_W   = $clog2(CREDITS + 1);
	localparam int DID_W   = `FSAB_DID_W;

	logic [CW-1:0]     last_grant;      // Client granted most recently
	logic [CW-1:0]     pick_idx;        // Round-robin winner this cycle
	logic              pick_found;      // Some queue is waiting
	logic [CRD_W-1:0]  mem_credits;     // Requests we may still issue
	logic              have_credit;

	// Search starts one past the last winner and wraps
	always_comb begin
		int cand;
		pick_found = 1'b0;
		pick_idx   = last_grant;
		for (int k = 1; k <= CLIENTS; k++) begin
			cand = (int'(last_grant) + k) % CLIENTS;
			if (!pick_found && q_nonempty[cand]) begin
				pick_found = 1'b1;
				pick_idx   = CW'(cand);
			end
		end
	end

	assign have_credit = (mem_credits != '0);
	assign grant_valid = pick_found && have_credit;    // Stall everyone when out of credit
	assign grant_req   = q_head[pick_idx];             // Head of winning queue
	assign grant_did   = DID_W'(pick_idx);             // Client number becomes device id

	// Pop the winner in the same cycle as the grant
	always_comb begin
		for (int i = 0; i < CLIENTS; i++) begin
			q_pop[i] = grant_valid && (pick_idx == CW'(i));
		end
	end

	// Fairness pointer
	always_ff @(posedge cclk or negedge core_rst_b) begin
		if (!core_rst_b) begin
			last_grant <= CW'(CLIENTS - 1);            // First search begins at client 0
		end else if (grant_valid) begin
			last_grant <= pick_idx;
		end
	end

	// Memory credit counter
	// Grant spends one, credit pulse returns one, both cancel
	always_ff @(posedge cclk or negedge core_rst_b) begin
		if (!core_rst_b) begin
			mem_credits <= CRD_W'(CREDITS);            // Full allowance after reset
		end else begin
			case ({grant_valid, fsabo_credit})
				2'b10:   mem_credits <= mem_credits - 1'b1;
				2'b01:   mem_credits <= mem_credits + 1'b1;
				default: mem_credits <= mem_credits;
			endcase
		end
	end

endmodule

/* src/fsab_cfg.svh */
`ifndef FSAB_CFG_SVH
`define FSAB_CFG_SVH

// Client count and request field widths
`define FSAB_CLIENTS      3   // Bus clients sharing the port
`define FSAB_ADDR_W       31  // Request address
`define FSAB_DATA_W       64  // Write data
`define FSAB_MASK_W       8   // One bit per data byte
`define FSAB_LEN_W        3   // Burst length field
`define FSAB_DID_W        4   // Device and sub-device id

// Flow control
`define FSAB_QUEUE_DEPTH  4   // Entries per client queue, also initial client credits
`define FSAB_MEM_CREDITS  8   // Requests in flight before memory returns credits

// Reset and status
`define FSAB_RST_STAGES   16  // Reset release sequence length
`define FSAB_FLASH_CYCLES 50  // Read activity flash length

`endif

/* src/fsab_client_queue.sv */
`timescale 1ns/1ps
`include "fsab_cfg.svh"

module fsab_client_queue import fsab_pkg::*; #(
	parameter int DEPTH = `FSAB_QUEUE_DEPTH
) (
	input  logic                     cclk,
	input  logic                     core_rst_b,
	input  logic                     in_valid,   // One-cycle strobe, client spent a credit
	input  fsab_mode_e               in_mode,
	input  logic [`FSAB_DID_W-1:0]   in_subdid,
	input  logic [`FSAB_ADDR_W-1:0]  in_addr,
	input  logic [`FSAB_LEN_W-1:0]   in_len,
	input  logic [`FSAB_DATA_W-1:0]  in_data,
	input  logic [`FSAB_MASK_W-1:0]  in_mask,
	input  logic                     pop,        // From arbiter, head taken this cycle
	output logic                     nonempty,
	output fsab_req_t                head,
	output logic                     credit      // One pulse per released entry
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	fsab_req_t           mem [DEPTH];                // Entry storage, no reset
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    count;                      // Occupancy
	logic                full;
	logic                wr_en;
	logic                rd_en;
	fsab_req_t           in_req;

	// Circular increment, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full     = (count == CNT_W'(DEPTH));
	assign nonempty = (count != '0);
	assign rd_en    = pop && nonempty;                 // Ignore stray pops
	assign wr_en    = in_valid && (!full || rd_en);    // Full write dropped unless slot frees
	assign head     = mem[rd_ptr];                     // Head visible to arbiter

	// Gather loose fields into one record
	always_comb begin
		in_req.mode   = in_mode;
		in_req.subdid = in_subdid;
		in_req.addr   = in_addr;
		in_req.len    = in_len;
		in_req.data   = in_data;
		in_req.mask   = in_mask;
	end

	// Storage write, sampled with client_valid
	always_ff @(posedge cclk) begin
		if (wr_en) begin
			mem[wr_ptr] <= in_req;
		end
	end

	// Pointers, count and returned credit
	always_ff @(posedge cclk or negedge core_rst_b) begin
		if (!core_rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (rd_en) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;         // Push only
				2'b01:   count <= count - 1'b1;         // Pop only
				default: count <= count;                // Both or neither
			endcase
			credit <= rd_en;                            // Pulse the cycle after pop
		end
	end

endmodule

/* src/fsab_fabric.sv */
`timescale 1ns/1ps
`include "fsab_cfg.svh"

module fsab_fabric import fsab_pkg::*; (
	input  logic                                          cclk,
	input  logic                                          cclk_rst_cause_b,
	// Client lanes, one slice per client
	input  logic [`FSAB_CLIENTS-1:0]                      client_valid,
	input  logic [`FSAB_CLIENTS-1:0]                      client_mode,
	input  logic [`FSAB_CLIENTS-1:0][`FSAB_DID_W-1:0]     client_subdid,
	input  logic [`FSAB_CLIENTS-1:0][`FSAB_ADDR_W-1:0]    client_addr,
	input  logic [`FSAB_CLIENTS-1:0][`FSAB_LEN_W-1:0]     client_len,
	input  logic [`FSAB_CLIENTS-1:0][`FSAB_DATA_W-1:0]    client_data,
	input  logic [`FSAB_CLIENTS-1:0][`FSAB_MASK_W-1:0]    client_mask,
	output logic [`FSAB_CLIENTS-1:0]                      client_credit,
	// Memory side
	output logic                                          fsabo_valid,
	output fsab_mode_e                                    fsabo_mode,
	output logic [`FSAB_DID_W-1:0]                        fsabo_did,
	output logic [`FSAB_DID_W-1:0]                        fsabo_subdid,
	output logic [`FSAB_ADDR_W-1:0]                       fsabo_addr,
	output logic [`FSAB_LEN_W-1:0]                        fsabo_len,
	output logic [`FSAB_DATA_W-1:0]                       fsabo_data,
	output logic [`FSAB_MASK_W-1:0]                       fsabo_mask,
	input  logic                                          fsabo_credit,
	// Status
	output logic                                          rst_done,
	output logic                                          read_seen,
	output logic                                          read_recent
);

	localparam int CLIENTS = `FSAB_CLIENTS;
	localparam int STAGES  = `FSAB_RST_STAGES;

	logic [STAGES-1:0]       rst_seq;           // Ones shift in after cause release
	logic                    core_rst_b;        // Internal reset for all blocks

	logic [CLIENTS-1:0]      q_nonempty;
	logic [CLIENTS-1:0]      q_pop;
	fsab_req_t               q_head [CLIENTS];  // Queue heads toward arbiter

	logic                    grant_valid;
	fsab_req_t               grant_req;
	logic [`FSAB_DID_W-1:0]  grant_did;

	// Reset release sequencer
	// Cause drops all stages at once, release walks out one stage per clock
	always_ff @(posedge cclk or negedge cclk_rst_cause_b) begin
		if (!cclk_rst_cause_b) begin
			rst_seq <= '0;
		end else begin
			rst_seq <= {rst_seq[STAGES-2:0], 1'b1};
		end
	end

	assign core_rst_b = rst_seq[STAGES-1];      // Last stage
	assign rst_done   = core_rst_b;

	// Input side, one queue per client
	for (genvar i = 0; i < CLIENTS; i++) begin : g_queue
		fsab_client_queue #(
			.DEPTH      (`FSAB_QUEUE_DEPTH)
		) u_queue (
			.cclk       (cclk),
			.core_rst_b (core_rst_b),
			.in_valid   (client_valid[i]),
			.in_mode    (fsab_mode_e'(client_mode[i])),
			.in_subdid  (client_subdid[i]),
			.in_addr    (client_addr[i]),
			.in_len     (client_len[i]),
			.in_data    (client_data[i]),
			.in_mask    (client_mask[i]),
			.pop        (q_pop[i]),
			.nonempty   (q_nonempty[i]),
			.head       (q_head[i]),
			.credit     (client_credit[i])
		);
	end

	// Round-robin pick and memory credits
	fsab_arbiter u_arbiter (
		.cclk         (cclk),
		.core_rst_b   (core_rst_b),
		.q_nonempty   (q_nonempty),
		.q_head       (q_head),
		.fsabo_credit (fsabo_credit),
		.q_pop        (q_pop),
		.grant_valid  (grant_valid),
		.grant_req    (grant_req),
		.grant_did    (grant_did)
	);

	// Output register and read status
	fsab_issue u_issue (
		.cclk         (cclk),
		.core_rst_b   (core_rst_b),
		.grant_valid  (grant_valid),
		.grant_req    (grant_req),
		.grant_did    (grant_did),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_data   (fsabo_data),
		.fsabo_mask   (fsabo_mask),
		.read_seen    (read_seen),
		.read_recent  (read_recent)
	);

endmodule

/* src/fsab_issue.sv */
`timescale 1ns/1ps
`include "fsab_cfg.svh"

module fsab_issue import fsab_pkg::*; (
	input  logic                       cclk,
	input  logic                       core_rst_b,
	input  logic                       grant_valid,
	input  fsab_req_t                  grant_req,
	input  logic [`FSAB_DID_W-1:0]     grant_did,
	output logic                       fsabo_valid,   // One-cycle strobe per request
	output fsab_mode_e                 fsabo_mode,
	output logic [`FSAB_DID_W-1:0]     fsabo_did,
	output logic [`FSAB_DID_W-1:0]     fsabo_subdid,
	output logic [`FSAB_ADDR_W-1:0]    fsabo_addr,
	output logic [`FSAB_LEN_W-1:0]     fsabo_len,
	output logic [`FSAB_DATA_W-1:0]    fsabo_data,
	output logic [`FSAB_MASK_W-1:0]    fsabo_mask,
	output logic                       read_seen,     // Sticky until reset
	output logic                       read_recent    // Stretched read flash
);

	localparam int FLASH   = `FSAB_FLASH_CYCLES;
	localparam int FLASH_W = $clog2(FLASH + 1);

	logic [FLASH_W-1:0]  flash_cnt;     // Cycles of flash left
	logic                read_issued;   // Read on the bus this cycle

	// Strobe register
	always_ff @(posedge cclk or negedge core_rst_b) begin
		if (!core_rst_b) begin
			fsabo_valid <= 1'b0;
		end else begin
			fsabo_valid <= grant_valid;                // One cycle behind grant
		end
	end

	// Payload, only loaded on a grant
	always_ff @(posedge cclk) begin
		if (grant_valid) begin
			fsabo_mode   <= grant_req.mode;
			fsabo_did    <= grant_did;
			fsabo_subdid <= grant_req.subdid;
			fsabo_addr   <= grant_req.addr;
			fsabo_len    <= grant_req.len;
			fsabo_data   <= grant_req.data;
			fsabo_mask   <= grant_req.mask;
		end
	end

	// Taken from the registered bus, not from the grant
	assign read_issued = fsabo_valid && (fsabo_mode == FSAB_READ);

	// Flash counter and sticky flag
	// A new read reloads the count, so the flash runs from the last read
	always_ff @(posedge cclk or negedge core_rst_b) begin
		if (!core_rst_b) begin
			flash_cnt <= '0;
			read_seen <= 1'b0;
		end else begin
			if (read_issued) begin
				flash_cnt <= FLASH_W'(FLASH);          // Restart the flash
				read_seen <= 1'b1;
			end else if (flash_cnt != '0) begin
				flash_cnt <= flash_cnt - 1'b1;
			end
		end
	end

	assign read_recent = (flash_cnt != '0);           // High for FLASH cycles

endmodule

/* src/fsab_pkg.sv */
`include "fsab_cfg.svh"

package fsab_pkg;

	// Request mode as it appears on the bus
	typedef enum logic {
		FSAB_READ  = 1'b0,                    // Memory read
		FSAB_WRITE = 1'b1                     // Memory write with data and mask
	} fsab_mode_e;

	// One request as held in a client queue
	// Device id is not stored here, the arbiter adds it on grant
	typedef struct packed {
		fsab_mode_e                mode;      // Read or write
		logic [`FSAB_DID_W-1:0]    subdid;    // Client's own tag
		logic [`FSAB_ADDR_W-1:0]   addr;      // Target address
		logic [`FSAB_LEN_W-1:0]    len;       // Burst length
		logic [`FSAB_DATA_W-1:0]   data;      // Write payload
		logic [`FSAB_MASK_W-1:0]   mask;      // Byte enables
	} fsab_req_t;

endpackage
